/* verilog/border_settings.svh */
// border overlay settings
// coordinate and colour widths, box count and setup length
`ifndef BORDER_SETTINGS_SVH
`define BORDER_SETTINGS_SVH

// one coordinate, x or y
`define BORDER_COR_WIDTH 12

// one colour channel
`define BORDER_DATA_WIDTH 8

`define BORDER_BOXES 5

// border width field and transparency rate
`define BORDER_WIDTH_BITS 5
`define BORDER_RATE_BITS 2

// four coordinates per box
`define BORDER_STEPS (`BORDER_BOXES * 4)

`endif

/* verilog/border_pkg.sv */
// border overlay package
// point word shared by setup, region logic and checker
`include "border_settings.svh"

package border_pkg;

  // one point register word, read by name or by axis index
  typedef union packed {
    struct packed {
      logic [`BORDER_COR_WIDTH-1:0] x;  // upper half
      logic [`BORDER_COR_WIDTH-1:0] y;
    } xy;
    logic [1:0][`BORDER_COR_WIDTH-1:0] axis;  // 1 is x, 0 is y
  } point_u;

endpackage

/* verilog/border_box_if.sv */
// box rectangle bus
// inner and outer rectangles of every box plus setup status
`timescale 1ns/1ns
`include "border_settings.svh"

interface border_box_if;

  // captured register points
  border_pkg::point_u inner_first  [`BORDER_BOXES];
  border_pkg::point_u inner_second [`BORDER_BOXES];

  // computed border rectangles
  border_pkg::point_u outer_first  [`BORDER_BOXES];
  border_pkg::point_u outer_second [`BORDER_BOXES];

  logic busy;  // setup running

  modport setup (
    output inner_first, inner_second, outer_first, outer_second, busy
  );

  modport region (
    input inner_first, inner_second, outer_first, outer_second, busy
  );

endinterface

/* verilog/border_coord_setup.sv */
// border coordinate setup
// walks the box coordinates one per cycle through a shared clamp adder
// and flips the finish toggle when all outer rectangles are written
`timescale 1ns/1ns
`include "border_settings.svh"

module border_coord_setup (
  input  logic                                          i_border_clk,
  input  logic                                          i_border_rst_n,
  input  logic                                          i_fstr,
  input  logic                                          i_border_trg,
  input  logic [`BORDER_BOXES*2*`BORDER_COR_WIDTH-1:0]  i_coord_1st,
  input  logic [`BORDER_BOXES*2*`BORDER_COR_WIDTH-1:0]  i_coord_2nd,
  input  logic [`BORDER_WIDTH_BITS-1:0]                 i_border_width,
  input  logic [`BORDER_COR_WIDTH-1:0]                  i_dest_hwin,
  input  logic [`BORDER_COR_WIDTH-1:0]                  i_dest_vwin,
  border_box_if.setup                                   box,
  output logic                                          o_finish_tgl
);

  localparam int CW        = `BORDER_COR_WIDTH;
  localparam int PW        = 2 * CW;
  localparam int STEP_BITS = $clog2(`BORDER_STEPS + 1);
  localparam int BOX_BITS  = $clog2(`BORDER_BOXES);

  logic                          trg_pend;  // trigger waiting for frame start
  logic                          start;
  logic                          last;
  logic                          write_en;
  logic [STEP_BITS-1:0]          step;
  logic [`BORDER_WIDTH_BITS-1:0] width_q;
  logic [BOX_BITS-1:0]           sel_box;
  logic                          sel_second;
  logic                          sel_axis;
  border_pkg::point_u            src_pt;
  logic [CW-1:0]                 inner;
  logic [CW-1:0]                 win;
  logic [CW+1:0]                 width_ext;
  logic [CW+1:0]                 addend;
  logic [CW+1:0]                 sum;
  logic [CW-1:0]                 outer;

  assign start    = i_fstr & trg_pend & ~box.busy;
  assign last     = (step == STEP_BITS'(`BORDER_STEPS));
  assign write_en = box.busy & ~last;

  // step is box*4 + {second, y}
  assign sel_box    = BOX_BITS'(step >> 2);
  assign sel_second = step[1];
  assign sel_axis   = ~step[0];  // 1 selects x

  assign src_pt = sel_second ? i_coord_2nd[sel_box*PW +: PW] : i_coord_1st[sel_box*PW +: PW];
  assign inner  = src_pt.axis[sel_axis];
  assign win    = sel_axis ? i_dest_hwin : i_dest_vwin;

  // single adder, width subtracted for first points and added for second
  assign width_ext = (CW+2)'(width_q);
  assign addend    = sel_second ? width_ext : -width_ext;
  assign sum       = {2'b00, inner} + addend;

  always_comb begin
    if (!sel_second)
      outer = sum[CW+1] ? '0 : sum[CW-1:0];  // floor at zero
    else if (sum >= {2'b00, win})
      outer = win - 1'b1;                   // cap at last column or line
    else
      outer = sum[CW-1:0];
  end

  always_ff @(posedge i_border_clk or negedge i_border_rst_n) begin
    if (!i_border_rst_n) begin
      trg_pend     <= 1'b0;
      box.busy     <= 1'b0;
      step         <= '0;
      o_finish_tgl <= 1'b0;
    end else begin
      trg_pend <= (trg_pend & ~start) | i_border_trg;
      if (start) begin
        box.busy <= 1'b1;
        step     <= '0;
      end else if (box.busy) begin
        if (last) begin
          box.busy     <= 1'b0;
          o_finish_tgl <= ~o_finish_tgl;
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  // width held for the whole walk
  always_ff @(posedge i_border_clk) begin
    if (start)
      width_q <= i_border_width;
  end

  always_ff @(posedge i_border_clk or negedge i_border_rst_n) begin
    if (!i_border_rst_n) begin
      for (int b = 0; b < `BORDER_BOXES; b++) begin
        box.inner_first[b]  <= '0;
        box.inner_second[b] <= '0;
        box.outer_first[b]  <= '0;
        box.outer_second[b] <= '0;
      end
    end else if (write_en) begin
      if (sel_second) begin
        box.inner_second[sel_box].axis[sel_axis] <= inner;
        box.outer_second[sel_box].axis[sel_axis] <= outer;
      end else begin
        box.inner_first[sel_box].axis[sel_axis] <= inner;
        box.outer_first[sel_box].axis[sel_axis] <= outer;
      end
    end
  end

endmodule

/* verilog/border_region.sv */
// border region detect
// pixel and line counters, per box test for outer but not inner rectangle
`timescale 1ns/1ns
`include "border_settings.svh"

module border_region (
  input  logic                     i_border_clk,
  input  logic                     i_border_rst_n,
  input  logic                     i_fstr,
  input  logic                     i_hend,
  input  logic                     i_dvld,
  input  logic [`BORDER_BOXES-1:0] i_border_en,
  border_box_if.region             box,
  output logic                     o_border_hit
);

  localparam int CW = `BORDER_COR_WIDTH;

  logic [CW-1:0]            pix_cnt;
  logic [CW-1:0]            line_cnt;
  logic [`BORDER_BOXES-1:0] in_outer;
  logic [`BORDER_BOXES-1:0] in_inner;

  // inclusive on all four edges
  function automatic logic in_rect(
    input border_pkg::point_u p1,
    input border_pkg::point_u p2,
    input logic [CW-1:0]      x,
    input logic [CW-1:0]      y
  );
    return (x >= p1.xy.x) && (x <= p2.xy.x) && (y >= p1.xy.y) && (y <= p2.xy.y);
  endfunction

  always_ff @(posedge i_border_clk or negedge i_border_rst_n) begin
    if (!i_border_rst_n) begin
      pix_cnt  <= '0;
      line_cnt <= '0;
    end else begin
      if (i_fstr | i_hend)
        pix_cnt <= '0;
      else if (i_dvld)
        pix_cnt <= pix_cnt + 1'b1;  // next pixel position

      if (i_fstr)
        line_cnt <= '0;
      else if (i_hend)
        line_cnt <= line_cnt + 1'b1;
    end
  end

  always_comb begin
    for (int b = 0; b < `BORDER_BOXES; b++) begin
      in_outer[b] = in_rect(box.outer_first[b], box.outer_second[b], pix_cnt, line_cnt);
      in_inner[b] = in_rect(box.inner_first[b], box.inner_second[b], pix_cnt, line_cnt);
    end
  end

  // rectangles are half written while busy
  assign o_border_hit = i_dvld & ~box.busy & (|(in_outer & ~in_inner & i_border_en));

endmodule

/* verilog/border_blend.sv */
// border colour blend
// mixes hit pixels with the frame colour and registers data and syncs
`timescale 1ns/1ns
`include "border_settings.svh"

module border_blend (
  input  logic                          i_border_clk,
  input  logic                          i_border_rst_n,
  input  logic                          i_fstr,
  input  logic                          i_hstr,
  input  logic                          i_hend,
  input  logic                          i_vstr,
  input  logic                          i_vend,
  input  logic                          i_dvld,
  input  logic [`BORDER_DATA_WIDTH-1:0] i_data_y,
  input  logic [`BORDER_DATA_WIDTH-1:0] i_data_cb,
  input  logic [`BORDER_DATA_WIDTH-1:0] i_data_cr,
  input  logic                          i_border_hit,
  input  logic [`BORDER_DATA_WIDTH-1:0] i_border_y,
  input  logic [`BORDER_DATA_WIDTH-1:0] i_border_cb,
  input  logic [`BORDER_DATA_WIDTH-1:0] i_border_cr,
  input  logic [`BORDER_RATE_BITS-1:0]  i_trn_rate,
  output logic                          o_hstr,
  output logic                          o_hend,
  output logic                          o_vstr,
  output logic                          o_vend,
  output logic                          o_dvld,
  output logic [`BORDER_DATA_WIDTH-1:0] o_data_y,
  output logic [`BORDER_DATA_WIDTH-1:0] o_data_cb,
  output logic [`BORDER_DATA_WIDTH-1:0] o_data_cr
);

  localparam int DW = `BORDER_DATA_WIDTH;

  logic [DW-1:0] col_y;
  logic [DW-1:0] col_cb;
  logic [DW-1:0] col_cr;

  // p pixel, c border colour, sum wraps at channel width
  function automatic logic [DW-1:0] blend(
    input logic [DW-1:0]                p,
    input logic [DW-1:0]                c,
    input logic [`BORDER_RATE_BITS-1:0] rate
  );
    case (rate)
      0:       return c;                                // solid
      1:       return (p >> 1) + (c >> 1);
      2:       return (p >> 2) + (c >> 1) + (c >> 2);
      default: return (p >> 1) + (p >> 2) + (c >> 2);  // mostly pixel
    endcase
  endfunction

  // colour fixed for the whole frame
  always_ff @(posedge i_border_clk) begin
    if (i_fstr) begin
      col_y  <= i_border_y;
      col_cb <= i_border_cb;
      col_cr <= i_border_cr;
    end
  end

  always_ff @(posedge i_border_clk or negedge i_border_rst_n) begin
    if (!i_border_rst_n) begin
      o_hstr    <= 1'b0;
      o_hend    <= 1'b0;
      o_vstr    <= 1'b0;
      o_vend    <= 1'b0;
      o_dvld    <= 1'b0;
      o_data_y  <= '0;
      o_data_cb <= '0;
      o_data_cr <= '0;
    end else begin
      o_hstr    <= i_hstr;
      o_hend    <= i_hend;
      o_vstr    <= i_vstr;
      o_vend    <= i_vend;
      o_dvld    <= i_dvld;
      o_data_y  <= i_border_hit ? blend(i_data_y, col_y, i_trn_rate) : i_data_y;
      o_data_cb <= i_border_hit ? blend(i_data_cb, col_cb, i_trn_rate) : i_data_cb;
      o_data_cr <= i_border_hit ? blend(i_data_cr, col_cr, i_trn_rate) : i_data_cr;
    end
  end

endmodule

/* verilog/border_top.sv */
// border overlay top
// draws up to five box borders on a YCbCr stream with one cycle latency
`timescale 1ns/1ns
`include "border_settings.svh"

module border_top (
  input  logic                                          border_clk,
  input  logic                                          border_rst_n,
  input  logic                                          i_fstr,
  input  logic                                          i_hstr,
  input  logic                                          i_hend,
  input  logic                                          i_vstr,
  input  logic                                          i_vend,
  input  logic                                          i_dvld,
  input  logic [`BORDER_DATA_WIDTH-1:0]                 i_data_y,
  input  logic [`BORDER_DATA_WIDTH-1:0]                 i_data_cb,
  input  logic [`BORDER_DATA_WIDTH-1:0]                 i_data_cr,
  input  logic                                          i_border_trg,
  input  logic [`BORDER_BOXES-1:0]                      i_border_en,
  input  logic [`BORDER_DATA_WIDTH-1:0]                 i_border_y,
  input  logic [`BORDER_DATA_WIDTH-1:0]                 i_border_cb,
  input  logic [`BORDER_DATA_WIDTH-1:0]                 i_border_cr,
  input  logic [`BORDER_WIDTH_BITS-1:0]                 i_border_width,
  input  logic [`BORDER_RATE_BITS-1:0]                  i_trn_rate,
  input  logic [`BORDER_BOXES*2*`BORDER_COR_WIDTH-1:0]  i_coord_1st,
  input  logic [`BORDER_BOXES*2*`BORDER_COR_WIDTH-1:0]  i_coord_2nd,
  input  logic [`BORDER_COR_WIDTH-1:0]                  i_dest_hwin,
  input  logic [`BORDER_COR_WIDTH-1:0]                  i_dest_vwin,
  output logic                                          o_hstr,
  output logic                                          o_hend,
  output logic                                          o_vstr,
  output logic                                          o_vend,
  output logic                                          o_dvld,
  output logic [`BORDER_DATA_WIDTH-1:0]                 o_data_y,
  output logic [`BORDER_DATA_WIDTH-1:0]                 o_data_cb,
  output logic [`BORDER_DATA_WIDTH-1:0]                 o_data_cr,
  output logic                                          o_finish_tgl
);

  logic border_hit;  // current input pixel is on a border

  border_box_if u_box ();

  border_coord_setup u_setup (
    .i_border_clk   (border_clk),
    .i_border_rst_n (border_rst_n),
    .i_fstr         (i_fstr),
    .i_border_trg   (i_border_trg),
    .i_coord_1st    (i_coord_1st),
    .i_coord_2nd    (i_coord_2nd),
    .i_border_width (i_border_width),
    .i_dest_hwin    (i_dest_hwin),
    .i_dest_vwin    (i_dest_vwin),
    .box            (u_box.setup),
    .o_finish_tgl   (o_finish_tgl)
  );

  border_region u_region (
    .i_border_clk   (border_clk),
    .i_border_rst_n (border_rst_n),
    .i_fstr         (i_fstr),
    .i_hend         (i_hend),
    .i_dvld         (i_dvld),
    .i_border_en    (i_border_en),
    .box            (u_box.region),
    .o_border_hit   (border_hit)
  );

  border_blend u_blend (
    .i_border_clk   (border_clk),
    .i_border_rst_n (border_rst_n),
    .i_fstr         (i_fstr),
    .i_hstr         (i_hstr),
    .i_hend         (i_hend),
    .i_vstr         (i_vstr),
    .i_vend         (i_vend),
    .i_dvld         (i_dvld),
    .i_data_y       (i_data_y),
    .i_data_cb      (i_data_cb),
    .i_data_cr      (i_data_cr),
    .i_border_hit   (border_hit),
    .i_border_y     (i_border_y),
    .i_border_cb    (i_border_cb),
    .i_border_cr    (i_border_cr),
    .i_trn_rate     (i_trn_rate),
    .o_hstr         (o_hstr),
    .o_hend         (o_hend),
    .o_vstr         (o_vstr),
    .o_vend         (o_vend),
    .o_dvld         (o_dvld),
    .o_data_y       (o_data_y),
    .o_data_cb      (o_data_cb),
    .o_data_cr      (o_data_cr)
  );

endmodule

/* verif/border_assertions.sv */
// border overlay checker
// own model of setup, counters and blend, compared with the DUT outputs
`timescale 1ns/1ns
`include "border_settings.svh"

module border_assertions (
  input logic                                       border_clk,
  input logic                                       border_rst_n,
  input logic                                       i_fstr, i_hstr, i_hend, i_vstr, i_vend,
  input logic                                       i_dvld,
  input logic [`BORDER_DATA_WIDTH-1:0]              i_data_y, i_data_cb, i_data_cr,
  input logic                                       i_border_trg,
  input logic [`BORDER_BOXES-1:0]                   i_border_en,
  input logic [`BORDER_DATA_WIDTH-1:0]              i_border_y, i_border_cb, i_border_cr,
  input logic [`BORDER_WIDTH_BITS-1:0]              i_border_width,
  input logic [`BORDER_RATE_BITS-1:0]               i_trn_rate,
  input logic [`BORDER_BOXES*2*`BORDER_COR_WIDTH-1:0] i_coord_1st, i_coord_2nd,
  input logic [`BORDER_COR_WIDTH-1:0]               i_dest_hwin, i_dest_vwin,
  input logic                                       o_hstr, o_hend, o_vstr, o_vend, o_dvld,
  input logic [`BORDER_DATA_WIDTH-1:0]              o_data_y, o_data_cb, o_data_cr,
  input logic                                       o_finish_tgl
);

  localparam int CW           = `BORDER_COR_WIDTH;
  localparam int DW           = `BORDER_DATA_WIDTH;
  localparam int PW           = 2 * CW;
  localparam int SETUP_CYCLES = `BORDER_STEPS + 1;  // toggle edge after frame start

  int unsigned        fail_cnt    = 0;  // polled by the testbench
  logic               reset_seen  = 1'b0;
  logic               active_seen = 1'b0;
  logic               pend;
  logic               start;
  logic [5:0]         busy_cnt;
  logic               tgl;
  logic [CW-1:0]      pix_m;
  logic [CW-1:0]      line_m;
  logic [DW-1:0]      col_y, col_cb, col_cr;
  border_pkg::point_u in1  [`BORDER_BOXES];
  border_pkg::point_u in2  [`BORDER_BOXES];
  border_pkg::point_u out1 [`BORDER_BOXES];
  border_pkg::point_u out2 [`BORDER_BOXES];
  logic               hit_now;
  logic               hit_q;
  logic [4:0]         sync_q;
  logic [3*DW-1:0]    data_q;
  logic [3*DW-1:0]    blend_q;
  logic [4:0]         sync_o;
  logic [3*DW-1:0]    data_o;

  // first point moves out by the width but never below zero
  function automatic border_pkg::point_u shrink_first(border_pkg::point_u p, logic [4:0] w);
    border_pkg::point_u r;
    r.xy.x = (p.xy.x < w) ? '0 : p.xy.x - w;
    r.xy.y = (p.xy.y < w) ? '0 : p.xy.y - w;
    return r;
  endfunction

  // second point moves out by the width up to the last column or line
  function automatic border_pkg::point_u grow_second(border_pkg::point_u p, logic [4:0] w,
                                                     logic [CW-1:0] hw, logic [CW-1:0] vw);
    border_pkg::point_u r;
    r.xy.x = ({1'b0, p.xy.x} + w >= {1'b0, hw}) ? hw - 1'b1 : p.xy.x + w;
    r.xy.y = ({1'b0, p.xy.y} + w >= {1'b0, vw}) ? vw - 1'b1 : p.xy.y + w;
    return r;
  endfunction

  function automatic logic covers(border_pkg::point_u a, border_pkg::point_u b,
                                  logic [CW-1:0] x, logic [CW-1:0] y);
    return (a.xy.x <= x) && (x <= b.xy.x) && (a.xy.y <= y) && (y <= b.xy.y);
  endfunction

  function automatic logic [DW-1:0] mix(logic [DW-1:0] p, logic [DW-1:0] c, logic [1:0] r);
    logic [DW-1:0] p2, p4, c2, c4;
    p2 = p >> 1;
    p4 = p >> 2;
    c2 = c >> 1;
    c4 = c >> 2;
    case (r)
      2'd0:    return c;
      2'd1:    return p2 + c2;
      2'd2:    return p4 + c2 + c4;
      default: return p2 + p4 + c4;
    endcase
  endfunction

  assign start  = i_fstr & pend & (busy_cnt == 0);
  assign sync_o = {o_hstr, o_hend, o_vstr, o_vend, o_dvld};
  assign data_o = {o_data_y, o_data_cb, o_data_cr};

  always_comb begin
    hit_now = 1'b0;
    for (int b = 0; b < `BORDER_BOXES; b++) begin
      if (i_border_en[b] && covers(out1[b], out2[b], pix_m, line_m)
          && !covers(in1[b], in2[b], pix_m, line_m))
        hit_now = 1'b1;
    end
    hit_now = hit_now & i_dvld & (busy_cnt == 0);  // nothing drawn during setup
  end

  // setup model takes the rectangles whole at frame start
  always_ff @(posedge border_clk or negedge border_rst_n) begin
    if (!border_rst_n) begin
      pend     <= 1'b0;
      busy_cnt <= '0;
      tgl      <= 1'b0;
      for (int b = 0; b < `BORDER_BOXES; b++) begin
        in1[b]  <= '0;
        in2[b]  <= '0;
        out1[b] <= '0;
        out2[b] <= '0;
      end
    end else begin
      pend <= (pend & ~start) | i_border_trg;
      if (start) begin
        busy_cnt <= 6'(SETUP_CYCLES);
        for (int b = 0; b < `BORDER_BOXES; b++) begin
          in1[b]  <= i_coord_1st[b*PW +: PW];
          in2[b]  <= i_coord_2nd[b*PW +: PW];
          out1[b] <= shrink_first(i_coord_1st[b*PW +: PW], i_border_width);
          out2[b] <= grow_second(i_coord_2nd[b*PW +: PW], i_border_width,
                                 i_dest_hwin, i_dest_vwin);
        end
      end else if (busy_cnt != 0) begin
        busy_cnt <= busy_cnt - 1'b1;
        if (busy_cnt == 6'd1)
          tgl <= ~tgl;
      end
    end
  end

  always_ff @(posedge border_clk or negedge border_rst_n) begin
    if (!border_rst_n) begin
      pix_m   <= '0;
      line_m  <= '0;
      hit_q   <= 1'b0;
      sync_q  <= '0;
      data_q  <= '0;
      blend_q <= '0;
    end else begin
      if (i_fstr || i_hend)
        pix_m <= '0;
      else if (i_dvld)
        pix_m <= pix_m + 1'b1;
      if (i_fstr)
        line_m <= '0;
      else if (i_hend)
        line_m <= line_m + 1'b1;
      hit_q   <= hit_now;
      sync_q  <= {i_hstr, i_hend, i_vstr, i_vend, i_dvld};
      data_q  <= {i_data_y, i_data_cb, i_data_cr};
      blend_q <= {mix(i_data_y, col_y, i_trn_rate), mix(i_data_cb, col_cb, i_trn_rate),
                  mix(i_data_cr, col_cr, i_trn_rate)};
    end
  end

  always_ff @(posedge border_clk) begin
    if (i_fstr) begin
      col_y  <= i_border_y;
      col_cb <= i_border_cb;
      col_cr <= i_border_cr;
    end
    if (!border_rst_n)
      reset_seen <= 1'b1;
    else if (i_fstr | i_hstr | i_hend | i_vstr | i_vend | i_dvld
             | (|{i_data_y, i_data_cb, i_data_cr}))
      active_seen <= 1'b1;  // first stream activity
  end

  a_idle: assert property (@(posedge border_clk)
    (reset_seen && !active_seen) |-> ({sync_o, data_o, o_finish_tgl} == '0))
    else begin
      fail_cnt++;
      $error("error {sync_o, data_o, o_finish_tgl} %h expected 0",
             $sampled({sync_o, data_o, o_finish_tgl}));
    end

  a_sync: assert property (@(posedge border_clk) disable iff (!border_rst_n)
    sync_o == sync_q)
    else begin
      fail_cnt++;
      $error("error sync_o %h expected %h", $sampled(sync_o), $sampled(sync_q));
    end

  a_pass: assert property (@(posedge border_clk) disable iff (!border_rst_n)
    !hit_q |-> data_o == data_q)
    else begin
      fail_cnt++;
      $error("error data_o %h expected %h", $sampled(data_o), $sampled(data_q));
    end

  a_blend: assert property (@(posedge border_clk) disable iff (!border_rst_n)
    hit_q |-> data_o == blend_q)
    else begin
      fail_cnt++;
      $error("error data_o %h expected %h", $sampled(data_o), $sampled(blend_q));
    end

  a_tgl: assert property (@(posedge border_clk) disable iff (!border_rst_n)
    o_finish_tgl == tgl)
    else begin
      fail_cnt++;
      $error("error o_finish_tgl %h expected %h", $sampled(o_finish_tgl), $sampled(tgl));
    end

endmodule

/* verif/border_tb.sv */
// border overlay testbench
// sends four frames through the DUT, the bound checker does the compare
`timescale 1ns/1ns
`include "border_settings.svh"

module border_tb;

  localparam int CW           = `BORDER_COR_WIDTH;
  localparam int PW           = 2 * CW;
  localparam int HPIX         = 64;
  localparam int VLINES       = 16;
  localparam int FRAME_CYCLES = 1 + 30 + VLINES * (HPIX + 8);
  localparam int TIMEOUT      = 4 * FRAME_CYCLES * 5 / 3;  // four frames plus margin

  logic                                         border_clk;
  logic                                         border_rst_n;
  logic                                         i_fstr, i_hstr, i_hend, i_vstr, i_vend;
  logic                                         i_dvld;
  logic [`BORDER_DATA_WIDTH-1:0]                i_data_y, i_data_cb, i_data_cr;
  logic                                         i_border_trg;
  logic [`BORDER_BOXES-1:0]                     i_border_en;
  logic [`BORDER_DATA_WIDTH-1:0]                i_border_y, i_border_cb, i_border_cr;
  logic [`BORDER_WIDTH_BITS-1:0]                i_border_width;
  logic [`BORDER_RATE_BITS-1:0]                 i_trn_rate;
  logic [`BORDER_BOXES*2*`BORDER_COR_WIDTH-1:0] i_coord_1st, i_coord_2nd;
  logic [`BORDER_COR_WIDTH-1:0]                 i_dest_hwin, i_dest_vwin;
  logic                                         o_hstr, o_hend, o_vstr, o_vend, o_dvld;
  logic [`BORDER_DATA_WIDTH-1:0]                o_data_y, o_data_cb, o_data_cr;
  logic                                         o_finish_tgl;
  int unsigned                                  cycles = 0;

  border_top i_dut (.*);

  bind border_top border_assertions u_chk (.*);

  initial begin
    border_clk = 1'b0;
    forever #10 border_clk = ~border_clk;
  end

  // first failed assertion or timeout ends the run
  always @(posedge border_clk) begin
    cycles <= cycles + 1;
    if (i_dut.u_chk.fail_cnt != 0) begin
      $display("an assertion in the checker failed");
      $display("test failed");
      $fatal(1, "stopped at first error");
    end else if (cycles >= TIMEOUT) begin
      $display("run timed out after %0d cycles", cycles);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge border_clk);
      {i_fstr, i_hstr, i_hend, i_vstr, i_vend, i_dvld} = '0;
      {i_data_y, i_data_cb, i_data_cr} = '0;
    end
  endtask

  task automatic set_box(input int b, input int x1, input int y1, input int x2, input int y2);
    i_coord_1st[b*PW +: PW] = {CW'(x1), CW'(y1)};  // x in upper half
    i_coord_2nd[b*PW +: PW] = {CW'(x2), CW'(y2)};
  endtask

  // rate_top for the upper half of the lines, rate_bot for the rest
  task automatic send_frame(input logic trg, input logic [1:0] rate_top,
                            input logic [1:0] rate_bot);
    if (trg) begin
      @(negedge border_clk);
      i_border_trg = 1'b1;
      @(negedge border_clk);
      i_border_trg = 1'b0;
    end
    @(negedge border_clk);
    i_fstr = 1'b1;
    idle_cycles(30);
    for (int ln = 0; ln < VLINES; ln++) begin
      for (int px = 0; px < HPIX; px++) begin
        @(negedge border_clk);
        i_trn_rate = (ln < VLINES / 2) ? rate_top : rate_bot;
        i_dvld     = 1'b1;
        i_hstr     = (px == 0);
        i_hend     = (px == HPIX - 1);
        i_vstr     = (ln == 0) && (px == 0);
        i_vend     = (ln == VLINES - 1) && (px == HPIX - 1);
        i_data_y   = 8'($urandom);
        i_data_cb  = 8'($urandom);
        i_data_cr  = 8'($urandom);
      end
      idle_cycles(8);
    end
  endtask

  initial begin
    void'($urandom(32'h410295d0));
    border_rst_n = 1'b0;
    {i_fstr, i_hstr, i_hend, i_vstr, i_vend, i_dvld} = '0;
    {i_data_y, i_data_cb, i_data_cr} = '0;
    i_border_trg   = 1'b0;
    i_border_en    = '0;
    i_border_y     = 8'h51;
    i_border_cb    = 8'h5a;
    i_border_cr    = 8'hf0;
    i_border_width = 5'd6;
    i_trn_rate     = '0;
    i_coord_1st    = '0;
    i_coord_2nd    = '0;
    i_dest_hwin    = CW'(HPIX);
    i_dest_vwin    = CW'(VLINES);
    repeat (4) @(negedge border_clk);
    border_rst_n = 1'b1;
    idle_cycles(4);

    send_frame(1'b0, 2'd0, 2'd0);  // no trigger, rectangles stay zero

    set_box(0, 3, 4, 20, 10);      // x 3 below width 6, clamps at column 0
    set_box(1, 30, 2, 45, 8);
    i_border_en = 5'b00011;
    send_frame(1'b1, 2'd0, 2'd0);

    set_box(1, 50, 3, 60, 9);      // 60 + 6 past the window, clamps at 63
    i_border_y  = 8'h10;
    i_border_cr = 8'h80;
    send_frame(1'b1, 2'd1, 2'd2);

    i_border_en = 5'b00001;        // box 1 pixels pass untouched
    send_frame(1'b0, 2'd3, 2'd3);
    idle_cycles(4);

    if (i_dut.u_chk.fail_cnt == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "checker reported errors");
    end
  end

endmodule

/* sources.f */
+incdir+verilog
verilog/border_pkg.sv
verilog/border_box_if.sv
verilog/border_coord_setup.sv
verilog/border_region.sv
verilog/border_blend.sv
verilog/border_top.sv
verif/border_assertions.sv
verif/border_tb.sv
